// ==== cpu.f ====
src/cpu_pkg.sv
src/wb_bus.sv
src/instr_rom.sv
src/reg_file.sv
src/alu.sv
src/data_mem.sv
src/cpu.sv
verification/tb_cpu.sv

// ==== src/alu.sv ====
module alu (
	input  logic [cpu_pkg::xlen-1:0] a,
	input  logic [cpu_pkg::xlen-1:0] b,
	input  logic [2:0]               op,       // Low bits of the opcode
	output logic [cpu_pkg::xlen-1:0] result,
	output logic [2:0]               flags,
	output logic [2:0]               flag_wen  // Per-flag update enables
);

	localparam int msb = cpu_pkg::xlen - 1;

	logic [cpu_pkg::xlen-1:0]   sum;
	logic [cpu_pkg::xlen-1:0]   diff;
	logic [2*cpu_pkg::xlen-1:0] rot;
	logic [3:0]                 sh;
	logic                       add_ovf;
	logic                       sub_ovf;

	assign sh   = b[3:0];          // Shift amount
	assign sum  = a + b;           // Wraps
	assign diff = a - b;
	assign rot  = {a, a} >> sh;    // Low half is the rotated word

	// Signed overflow
	assign add_ovf = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
	assign sub_ovf = (a[msb] != b[msb]) && (diff[msb] != a[msb]);

	always_comb begin
		result   = '0;
		flags    = '0;
		flag_wen = '0;
		case (op)
			cpu_pkg::op_add[2:0]: begin
				result                 = sum;
				flags[cpu_pkg::flag_v] = add_ovf;
				flag_wen               = '1; // Z, V and N
			end
			cpu_pkg::op_sub[2:0]: begin
				result                 = diff;
				flags[cpu_pkg::flag_v] = sub_ovf;
				flag_wen               = '1;
			end
			cpu_pkg::op_xor[2:0]: begin
				result                    = a ^ b;
				flag_wen[cpu_pkg::flag_z] = 1'b1; // Z only
			end
			cpu_pkg::op_sll[2:0]: begin
				result                    = a << sh;
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			cpu_pkg::op_sra[2:0]: begin
				result                    = $signed(a) >>> sh; // Sign fill
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			cpu_pkg::op_ror[2:0]: begin
				result                    = rot[msb:0];
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			default: ; // Unused encodings, no result, no flag update
		endcase
		flags[cpu_pkg::flag_z] = (result == '0);
		flags[cpu_pkg::flag_n] = result[msb];
	end

endmodule

// ==== src/cpu.sv ====
module cpu (
	input  logic                     clk,
	input  logic                     rst_n,
	output logic                     hlt,
	output logic [cpu_pkg::xlen-1:0] pc_out,
	output logic                     wb_valid, // Register write-back trace
	output logic [3:0]               wb_reg,
	output logic [cpu_pkg::xlen-1:0] wb_data
);

	logic [cpu_pkg::xlen-1:0] pc;        // Fetch address
	logic [cpu_pkg::xlen-1:0] if_pc;     // Address of the word in execute
	logic                     if_valid;  // Execute holds a live instruction
	logic [cpu_pkg::xlen-1:0] rom_addr;
	logic [cpu_pkg::xlen-1:0] pc_plus2;
	cpu_pkg::instr_t          ir;        // ROM output, the execute instruction
	logic [3:0]               opc;
	logic                     is_alu, is_shift, is_lw, is_sw, is_mem;
	logic                     is_lhb, is_llb, is_b, is_br, is_pcs, is_hlt;
	logic                     reg_write, mem_req, stall, retire, ack_q;
	logic [3:0]               src1_sel, src2_sel;
	logic [cpu_pkg::xlen-1:0] rf_rs, rf_rt, src1, src2;
	logic [cpu_pkg::xlen-1:0] alu_b, alu_res, result, mem_addr, br_target;
	logic [2:0]               flags_q, alu_flags, alu_fwen;
	logic                     cond, take;

	wb_bus dbus ();

	instr_rom i_rom (
		.clk  (clk),
		.addr (rom_addr),
		.data (ir)
	);

	// --------------------------------------------------
	// Decode
	// --------------------------------------------------
	assign opc      = ir.r.opcode;
	assign is_alu   = opc inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_xor,
	                              cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror};
	assign is_shift = opc inside {cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror};
	assign is_lw    = (opc == cpu_pkg::op_lw);
	assign is_sw    = (opc == cpu_pkg::op_sw);
	assign is_mem   = is_lw | is_sw;
	assign is_lhb   = (opc == cpu_pkg::op_lhb);
	assign is_llb   = (opc == cpu_pkg::op_llb);
	assign is_b     = (opc == cpu_pkg::op_b);
	assign is_br    = (opc == cpu_pkg::op_br);
	assign is_pcs   = (opc == cpu_pkg::op_pcs);
	assign is_hlt   = (opc == cpu_pkg::op_hlt);
	assign reg_write = is_alu | is_lw | is_lhb | is_llb | is_pcs;

	// SW, LHB, LLB read rd first; loads and stores take rs as base
	assign src1_sel = (is_sw | is_lhb | is_llb) ? ir.r.rd : ir.r.rs;
	assign src2_sel = is_mem ? ir.r.rs : ir.r.rt;

	reg_file i_rf (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_sel  (src1_sel),
		.rt_sel  (src2_sel),
		.rd_sel  (wb_reg),
		.wr_en   (wb_valid),
		.wr_data (wb_data),
		.rs_data (rf_rs),
		.rt_data (rf_rt)
	);

	// Write-back values reach execute through the register file bypass
	assign src1 = rf_rs;
	assign src2 = rf_rt;

	// --------------------------------------------------
	// Execute
	// --------------------------------------------------
	assign alu_b = is_shift ? {12'd0, ir.r.rt} : src2; // imm4 shift amount

	alu i_alu (
		.a        (src1),
		.b        (alu_b),
		.op       (opc[2:0]),
		.result   (alu_res),
		.flags    (alu_flags),
		.flag_wen (alu_fwen)
	);

	assign pc_plus2 = if_pc + 16'd2;
	assign mem_addr = src2 + {{11{ir.r.rt[3]}}, ir.r.rt, 1'b0}; // Base + word offset

	always_comb begin
		if (is_lhb)
			result = {ir.i.imm8, src1[7:0]};
		else if (is_llb)
			result = {src1[15:8], ir.i.imm8};
		else if (is_pcs)
			result = pc_plus2;
		else
			result = alu_res;
	end

	// Branch unit, flags are those left by earlier instructions
	always_comb begin
		case (ir.b.cc)
			cpu_pkg::cc_ne: cond = !flags_q[cpu_pkg::flag_z];
			cpu_pkg::cc_eq: cond = flags_q[cpu_pkg::flag_z];
			cpu_pkg::cc_gt: cond = !flags_q[cpu_pkg::flag_z] && !flags_q[cpu_pkg::flag_n];
			cpu_pkg::cc_lt: cond = flags_q[cpu_pkg::flag_n];
			cpu_pkg::cc_ge: cond = flags_q[cpu_pkg::flag_z] || !flags_q[cpu_pkg::flag_n];
			cpu_pkg::cc_le: cond = flags_q[cpu_pkg::flag_z] || flags_q[cpu_pkg::flag_n];
			cpu_pkg::cc_ov: cond = flags_q[cpu_pkg::flag_v];
			cpu_pkg::cc_always: cond = 1'b1;
			default: cond = 1'b0;
		endcase
	end

	assign take      = if_valid & (is_b | is_br) & cond;
	assign br_target = is_br ? src1 : pc_plus2 + {{6{ir.b.imm9[8]}}, ir.b.imm9, 1'b0};

	// --------------------------------------------------
	// Wishbone master, gap cycle after each ack
	// --------------------------------------------------
	assign mem_req     = if_valid & is_mem;
	assign dbus.cyc    = mem_req & ~ack_q;
	assign dbus.stb    = mem_req & ~ack_q;
	assign dbus.we     = is_sw;
	assign dbus.adr    = mem_addr;
	assign dbus.dat_w  = src1; // Store data from rd

	assign stall    = mem_req & ~dbus.ack; // Only back-pressure
	assign retire   = if_valid & ~stall;
	assign rom_addr = stall ? if_pc : pc;  // Re-read the held word while stalled
	assign pc_out   = pc;

	data_mem i_dmem (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (dbus.slave)
	);

	// PC, fetch register, flags, halt
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc       <= '0;
			if_pc    <= '0;
			if_valid <= 1'b0;
			hlt      <= 1'b0;
			ack_q    <= 1'b0;
			flags_q  <= '0;
		end else begin
			ack_q <= dbus.ack;
			if (retire && is_alu)
				flags_q <= (alu_flags & alu_fwen) | (flags_q & ~alu_fwen);
			if (!hlt) begin
				if (if_valid && is_hlt) begin
					hlt      <= 1'b1; // PC holds from here on
					if_valid <= 1'b0;
				end else if (take) begin
					pc       <= br_target;
					if_valid <= 1'b0; // Squash the word in fetch
				end else if (!stall) begin
					pc       <= pc + 16'd2;
					if_pc    <= pc;
					if_valid <= 1'b1;
				end
			end
		end
	end

	// Write-back register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= retire & reg_write;
	end

	always_ff @(posedge clk) begin
		if (retire && reg_write) begin
			wb_reg  <= ir.r.rd;
			wb_data <= is_lw ? dbus.dat_r : result; // Load data captured on ack
		end
	end

	// Request held steady until the slave answers
	a_req_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(dbus.stb && !dbus.ack) |=> (dbus.stb && $stable(dbus.adr) && $stable(dbus.we))
	);

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	// --------------------------------------------------
	// Widths and memory sizes
	// --------------------------------------------------
	localparam int xlen       = 16;  // Data and address width
	localparam int rom_depth  = 256; // Program words
	localparam int dmem_depth = 256; // Data words

	// --------------------------------------------------
	// Opcodes, bits 15:12
	// --------------------------------------------------
	localparam logic [3:0] op_add = 4'h0;
	localparam logic [3:0] op_sub = 4'h1;
	localparam logic [3:0] op_xor = 4'h2;
	localparam logic [3:0] op_sll = 4'h4;
	localparam logic [3:0] op_sra = 4'h5;
	localparam logic [3:0] op_ror = 4'h6;
	localparam logic [3:0] op_lw  = 4'h8;
	localparam logic [3:0] op_sw  = 4'h9;
	localparam logic [3:0] op_lhb = 4'hA;
	localparam logic [3:0] op_llb = 4'hB;
	localparam logic [3:0] op_b   = 4'hC; // PC-relative target
	localparam logic [3:0] op_br  = 4'hD; // Register target
	localparam logic [3:0] op_pcs = 4'hE;
	localparam logic [3:0] op_hlt = 4'hF;

	// Branch conditions, bits 11:9 of B and BR
	localparam logic [2:0] cc_ne     = 3'b000;
	localparam logic [2:0] cc_eq     = 3'b001;
	localparam logic [2:0] cc_gt     = 3'b010;
	localparam logic [2:0] cc_lt     = 3'b011;
	localparam logic [2:0] cc_ge     = 3'b100;
	localparam logic [2:0] cc_le     = 3'b101;
	localparam logic [2:0] cc_ov     = 3'b110;
	localparam logic [2:0] cc_always = 3'b111;

	// Bit positions in the flag word
	localparam int flag_z = 2;
	localparam int flag_v = 1;
	localparam int flag_n = 0;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [3:0] rs;
			logic [3:0] rt; // Also imm4 for shifts and memory offset
		} r;
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [7:0] imm8; // LHB and LLB byte
		} i;
		struct packed {
			logic [3:0] opcode;
			logic [2:0] cc;
			logic [8:0] imm9; // Word offset from PC+2
		} b;
	} instr_t;

endpackage

// ==== src/data_mem.sv ====
module data_mem (
	input logic  clk,
	input logic  rst_n,
	wb_bus.slave bus
);

	logic [cpu_pkg::xlen-1:0]              mem [cpu_pkg::dmem_depth];
	logic [$clog2(cpu_pkg::dmem_depth)-1:0] idx;
	logic [1:0]                            wait_cnt;
	logic [1:0]                            wait_last; // Count at which ack is raised
	logic                                  req;

	assign idx       = bus.adr[$clog2(cpu_pkg::dmem_depth):1]; // Word index
	assign req       = bus.cyc & bus.stb;
	assign wait_last = bus.adr[1] ? 2'd2 : 2'd0; // Odd words take 3 cycles, even words 1
	assign bus.dat_r = mem[idx]; // Sampled by the master on ack

	// --------------------------------------------------
	// Wait-state counter and ack
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
			bus.ack  <= 1'b0;
		end else if (req && !bus.ack) begin
			bus.ack  <= (wait_cnt == wait_last);
			wait_cnt <= wait_cnt + 2'd1;
		end else begin
			// Ack lasts one cycle, then idle until the next strobe
			bus.ack  <= 1'b0;
			wait_cnt <= '0;
		end
	end

	// Storage, write lands on the ack cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::dmem_depth; i++)
				mem[i] <= '0;
		end else if (req && bus.ack && bus.we) begin
			mem[idx] <= bus.dat_w;
		end
	end

	// Ack only answers a live request from the master
	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		bus.ack |-> req
	);

endmodule

// ==== src/instr_rom.sv ====
module instr_rom (
	input  logic                     clk,
	input  logic [cpu_pkg::xlen-1:0] addr, // Byte address from the PC
	output logic [cpu_pkg::xlen-1:0] data
);

	// Program image
	logic [cpu_pkg::xlen-1:0] rom [cpu_pkg::rom_depth];
	logic [$clog2(cpu_pkg::rom_depth)-1:0] word_idx;

	initial begin
		$readmemh("verification/program.hex", rom);
	end

	// Byte address to word index, bit 0 dropped
	assign word_idx = addr[$clog2(cpu_pkg::rom_depth):1];

	// Registered read, word valid one cycle after addr
	always_ff @(posedge clk) begin
		data <= rom[word_idx];
	end

endmodule

// ==== src/reg_file.sv ====
module reg_file (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [3:0]               rs_sel,
	input  logic [3:0]               rt_sel,
	input  logic [3:0]               rd_sel,
	input  logic                     wr_en,
	input  logic [cpu_pkg::xlen-1:0] wr_data,
	output logic [cpu_pkg::xlen-1:0] rs_data,
	output logic [cpu_pkg::xlen-1:0] rt_data
);

	logic [cpu_pkg::xlen-1:0] regs [16];

	// One read port: r0 is zero, same-cycle write passes through
	function automatic logic [cpu_pkg::xlen-1:0] read_port(input logic [3:0] sel);
		if (sel == 4'd0)
			return '0;
		if (wr_en && (sel == rd_sel))
			return wr_data; // Bypass
		return regs[sel];
	endfunction

	always_comb begin
		rs_data = read_port(rs_sel);
		rt_data = read_port(rt_sel);
	end

	// Write port
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr_en && (rd_sel != 4'd0)) begin // r0 stays zero
			regs[rd_sel] <= wr_data;
		end
	end

endmodule

// ==== src/wb_bus.sv ====
interface wb_bus;

	logic                     cyc;   // Cycle in progress
	logic                     stb;   // Strobe, qualifies adr and data
	logic                     we;    // 1 = write
	logic [cpu_pkg::xlen-1:0] adr;   // Byte address
	logic [cpu_pkg::xlen-1:0] dat_w; // Master to slave
	logic [cpu_pkg::xlen-1:0] dat_r; // Slave to master
	logic                     ack;   // One cycle per transfer

	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_w,
		input  dat_r,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_w,
		output dat_r,
		output ack
	);

endinterface

// ==== verification/program.hex ====
// One 16-bit instruction word per line, in hex, starting at byte address 0
// Fields: opcode[15:12] rd[11:8] rs[7:4] rt[3:0], B/BR: cc[11:9] imm9[8:0]
B105 // LLB r1 05
A180 // LHB r1 80, r1 = 8005 via forwarding
B203 // LLB r2 03
0312 // ADD r3, N set
1431 // SUB r4 = 0003
2542 // XOR r5 = 0, Z set
4614 // SLL r6 by 4
5712 // SRA r7 by 2, sign fill
6814 // ROR r8 by 4
// Flags Z0 V0 N0 from here
C201 // B eq, not taken
BC01 // marker
C601 // B lt, not taken
BC02
CA01 // B le, not taken
BC03
CC01 // B ov, not taken
BC04
C001 // B ne, taken
BFEE // squashed
C401 // B gt, taken
BFEE
C801 // B ge, taken
BFEE
CE01 // B always
BFEE
1922 // SUB r9 = 0, Z set
C201 // B eq, taken
BFEE
CA01 // B le, taken
BFEE
C001 // B ne, not taken
BC05
C401 // B gt, not taken
BC06
C601 // B lt, not taken
BC07
0A12 // ADD r10, N set
C601 // B lt, taken
BFEE
C801 // B ge, not taken
BC08
0B11 // ADD r11 = r1 + r1, signed overflow
CC01 // B ov, taken
BFEE
// Memory over Wishbone, base 0x20
BD20 // LLB r13 20
93D0 // SW r3 to 0x20, one wait
97D1 // SW r7 to 0x22, three waits
98DF // SW r8 to 0x1E, negative offset
8ED0 // LW r14 from 0x20
8FD1 // LW r15 from 0x22
8EDF // LW r14 from 0x1E
0EEF // ADD r14 = r14 + r15, load forwarded
E500 // PCS r5
B670 // LLB r6 70
DE60 // BR always to r6
BFEE // squashed
D250 // BR eq, not taken
BC09 // marker
F000 // HLT
BFEE // never retires

// ==== verification/tb_cpu.sv ====
module tb_cpu;

	localparam int timeout_cycles = 200; // Per wait
	localparam int max_steps      = 1000; // Reference model step limit

	logic                     clk;
	logic                     rst_n;
	logic                     hlt;
	logic [cpu_pkg::xlen-1:0] pc_out;
	logic                     wb_valid;
	logic [3:0]               wb_reg;
	logic [cpu_pkg::xlen-1:0] wb_data;

	logic [cpu_pkg::xlen-1:0] prog [cpu_pkg::rom_depth]; // Same image as the ROM
	logic [3:0]               exp_reg [$];               // Expected write-back trace
	logic [cpu_pkg::xlen-1:0] exp_data [$];
	logic [cpu_pkg::xlen-1:0] halt_pc;                   // Address of the HLT word

	cpu i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.hlt      (hlt),
		.pc_out   (pc_out),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg),
		.wb_data  (wb_data)
	);

	// --------------------------------------------------
	// Clock and reset
	// --------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0; // Held low for 3 cycles
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
	end

	// --------------------------------------------------
	// Error reporting
	// --------------------------------------------------
	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic fail_with(input string what);
		$display("error at time %0t: %s", $time, what);
		abort_run();
	endtask

	task automatic report_mismatch(input string sig, input logic [15:0] got,
	                               input logic [15:0] want);
		$display("mismatch at time %0t: %s is %h, expected %h", $time, sig, got, want);
		abort_run();
	endtask

	// --------------------------------------------------
	// Instruction-set reference model
	// --------------------------------------------------
	function automatic logic cond_met(input logic [2:0] cc, input logic [2:0] f);
		logic z;
		logic v;
		logic n;
		z = f[cpu_pkg::flag_z];
		v = f[cpu_pkg::flag_v];
		n = f[cpu_pkg::flag_n];
		case (cc)
			cpu_pkg::cc_ne:     return !z;
			cpu_pkg::cc_eq:     return z;
			cpu_pkg::cc_gt:     return !z && !n;
			cpu_pkg::cc_lt:     return n;
			cpu_pkg::cc_ge:     return z || !n;
			cpu_pkg::cc_le:     return z || n;
			cpu_pkg::cc_ov:     return v;
			cpu_pkg::cc_always: return 1'b1;
			default:            return 1'b0;
		endcase
	endfunction

	// Runs the program on arrays, queues every register write, returns the count
	function automatic int run_reference();
		logic [15:0]     regs [16];
		logic [15:0]     mem [cpu_pkg::dmem_depth];
		logic [15:0]     pc, nxt, a, b, r, addr;
		logic [2:0]      flg;
		logic [3:0]      sh;
		logic            wr;
		cpu_pkg::instr_t ins;
		int              i;
		int              steps;
		pc  = '0;
		flg = '0;
		for (i = 0; i < 16; i++)
			regs[i] = '0;
		for (i = 0; i < cpu_pkg::dmem_depth; i++)
			mem[i] = '0;
		for (steps = 0; steps < max_steps; steps++) begin
			ins  = prog[pc[8:1]];
			nxt  = pc + 16'd2;
			wr   = 1'b0;
			r    = '0;
			sh   = ins.r.rt; // imm4 for shifts
			a    = regs[ins.r.rs];
			b    = regs[ins.r.rt];
			addr = a + ({{12{ins.r.rt[3]}}, ins.r.rt} << 1); // Base + word offset
			case (ins.r.opcode)
				cpu_pkg::op_add: begin
					r   = a + b;
					flg = {r == 16'd0, (a[15] == b[15]) && (r[15] != a[15]), r[15]};
					wr  = 1'b1;
				end
				cpu_pkg::op_sub: begin
					r   = a - b;
					flg = {r == 16'd0, (a[15] != b[15]) && (r[15] != a[15]), r[15]};
					wr  = 1'b1;
				end
				cpu_pkg::op_xor: r = a ^ b;
				cpu_pkg::op_sll: r = a << sh;
				cpu_pkg::op_sra: r = $signed(a) >>> sh;
				cpu_pkg::op_ror: r = (a >> sh) | (a << (5'd16 - sh)); // sh 0 keeps a
				cpu_pkg::op_lw: begin
					r  = mem[addr[8:1]];
					wr = 1'b1;
				end
				cpu_pkg::op_sw:  mem[addr[8:1]] = regs[ins.r.rd];
				cpu_pkg::op_lhb: begin
					r  = {ins.i.imm8, regs[ins.i.rd][7:0]};
					wr = 1'b1;
				end
				cpu_pkg::op_llb: begin
					r  = {regs[ins.i.rd][15:8], ins.i.imm8};
					wr = 1'b1;
				end
				cpu_pkg::op_b: begin
					if (cond_met(ins.b.cc, flg))
						nxt = nxt + {{6{ins.b.imm9[8]}}, ins.b.imm9, 1'b0};
				end
				cpu_pkg::op_br: begin
					if (cond_met(ins.b.cc, flg))
						nxt = a; // Register target
				end
				cpu_pkg::op_pcs: begin
					r  = pc + 16'd2;
					wr = 1'b1;
				end
				cpu_pkg::op_hlt: begin
					halt_pc = pc;
					return exp_reg.size();
				end
				default: ; // Unused opcodes do nothing
			endcase
			// XOR and shifts write rd and touch only Z
			if (ins.r.opcode inside {cpu_pkg::op_xor, cpu_pkg::op_sll,
			                         cpu_pkg::op_sra, cpu_pkg::op_ror}) begin
				flg[cpu_pkg::flag_z] = (r == 16'd0);
				wr = 1'b1;
			end
			if (wr) begin
				exp_reg.push_back(ins.r.rd);
				exp_data.push_back(r);
				if (ins.r.rd != 4'd0)
					regs[ins.r.rd] = r; // r0 stays zero
			end
			pc = nxt;
		end
		return -1; // No HLT reached
	endfunction

	// --------------------------------------------------
	// Timed waits, sampled on the falling edge
	// --------------------------------------------------
	task automatic wait_for_write();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert (!hlt || wb_valid)
				else fail_with("hlt rose while register writes were still expected");
			assert (cycles <= timeout_cycles)
				else fail_with("no register write within 200 cycles");
		end while (!wb_valid);
	endtask

	task automatic wait_for_halt();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert (!wb_valid) else fail_with("register write after the last expected one");
			assert (cycles <= timeout_cycles) else fail_with("hlt did not rise within 200 cycles");
		end while (!hlt);
	endtask

	// --------------------------------------------------
	// Trace comparison
	// --------------------------------------------------
	initial begin : compare
		int          n;
		int          cycles;
		logic [3:0]  want_reg;
		logic [15:0] want_data;
		logic [15:0] held_pc;
		$readmemh("verification/program.hex", prog);
		n = run_reference();
		assert (n > 0) else fail_with("reference model found no HLT in the program");

		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert (cycles <= 10) else fail_with("reset was never released");
		end while (!rst_n);

		// State right after reset
		assert (pc_out === 16'd0) else report_mismatch("pc_out", pc_out, 16'd0);
		assert (hlt === 1'b0) else report_mismatch("hlt", {15'd0, hlt}, 16'd0);
		assert (wb_valid === 1'b0) else report_mismatch("wb_valid", {15'd0, wb_valid}, 16'd0);

		while (exp_reg.size() > 0) begin
			want_reg  = exp_reg.pop_front();
			want_data = exp_data.pop_front();
			wait_for_write();
			assert (wb_reg === want_reg)
				else report_mismatch("wb_reg", {12'd0, wb_reg}, {12'd0, want_reg});
			assert (wb_data === want_data)
				else report_mismatch("wb_data", wb_data, want_data);
		end

		wait_for_halt();
		held_pc = halt_pc + 16'd2; // Fetch had moved past HLT
		repeat (20) begin // Core must stay frozen
			@(negedge clk);
			assert (pc_out === held_pc) else report_mismatch("pc_out", pc_out, held_pc);
			assert (hlt === 1'b1) else fail_with("hlt dropped after the halt");
			assert (!wb_valid) else fail_with("register write after the halt");
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule
